/* include/board_config.svh */
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Board I/O counts
`define w_key 2   // Push buttons, active low on the board
`define w_sw  10  // Slide switches, the top one is reset
`define w_led 10  // Red LEDs
`define w_hex 6   // Static seven-segment displays

`endif

/* hdl/board_pkg.sv */
package board_pkg;

    // --------------------
    // Display geometry

    localparam int n_digit     = 8;                // Scanned digits
    localparam int w_digit_idx = $clog2(n_digit);  // Scanner index width
    localparam int dot_digit   = 4;                // Digit carrying the separator dot

    typedef logic [7:0]           seg_t;        // abcdefgh, a in bit 7
    typedef logic [3:0]           nibble_t;     // One hex digit
    typedef logic [31:0]          count_t;      // Lab counter value
    typedef logic [n_digit - 1:0] digit_sel_t;  // One-hot digit select

    // --------------------
    // Rates, in clocks

    localparam int scan_div   = 8;    // Between scanner steps
    localparam int step_div   = 256;  // Between counter steps
    localparam int tm_bit_div = 2;    // Half period of sio_clk
    localparam int tm_gap     = 16;   // Idle between TM1638 frames

    // --------------------
    // TM1638 command bytes

    localparam seg_t tm_cmd_write = 8'h40;  // Data write, auto-increment
    localparam seg_t tm_cmd_addr  = 8'hC0;  // Start at address 0
    localparam seg_t tm_cmd_ctrl  = 8'h8F;  // Display on, full brightness

    // Scanned display bus
    typedef struct packed
    {
        seg_t       abcdefgh;  // Pattern of the selected digit
        digit_sel_t digit;     // Which digit it belongs to
    } scan_bus_t;

    // TM1638 transmitter states
    typedef enum logic [2:0] {IDLE, CMD, ADDR, DATA, CTRL, GAP} scan_state_t;

endpackage

/* hdl/rate_strobe.sv */
`timescale 1ns/1ps

module rate_strobe
#(
    parameter int div = 8
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int w_cnt = div > 1 ? $clog2(div) : 1;  // Survives div of 1

    logic [w_cnt - 1:0] cnt;  // Clocks since last tick

    assign tick = (cnt == w_cnt'(div - 1));  // Last clock of the period

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (tick)
            cnt <= '0;                      // Start next period
        else
            cnt <= cnt + w_cnt'(1);
    end

endmodule

/* hdl/hex_counter_lab.sv */
`timescale 1ns/1ps

`include "board_config.svh"

module hex_counter_lab
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  step_tick,  // Counter step enable
    input  logic [`w_key - 1:0]   key,        // Active high here
    input  logic [`w_sw - 2:0]    sw,         // Step increment minus one
    output board_pkg::count_t     count
);

    // --------------------
    // Key roles

    logic clear;  // Key 0
    logic hold;   // Key 1

    assign clear = key[0];
    assign hold  = key[1];

    // --------------------
    // Counter

    board_pkg::count_t step_size;  // Amount added per step

    assign step_size = board_pkg::count_t'(sw) + board_pkg::count_t'(1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else if (clear)
            count <= '0;                  // Clear wins over everything
        else if (step_tick && !hold)
            count <= count + step_size;   // Paused while key 1 is down
    end

endmodule

/* hdl/digit_scanner.sv */
`timescale 1ns/1ps

module digit_scanner
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 scan_tick,  // Advance to next digit
    input  board_pkg::count_t    count,      // Value to display
    output board_pkg::scan_bus_t scan        // Registered pattern and select
);

    logic [board_pkg::w_digit_idx - 1:0] idx;  // Current digit
    board_pkg::nibble_t                  nib;  // Its hex value
    board_pkg::seg_t                     pat;  // Decoded pattern

    // --------------------
    // Digit index

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            idx <= '0;
        else if (scan_tick)
            idx <= idx + 1'b1;  // Wraps after the last digit
    end

    assign nib = count[idx * 4 +: 4];

    // --------------------
    // Hex to abcdefgh

    always_comb
    begin
        case (nib)
            4'h0: pat = 8'b1111_1100;
            4'h1: pat = 8'b0110_0000;
            4'h2: pat = 8'b1101_1010;
            4'h3: pat = 8'b1111_0010;
            4'h4: pat = 8'b0110_0110;
            4'h5: pat = 8'b1011_0110;
            4'h6: pat = 8'b1011_1110;
            4'h7: pat = 8'b1110_0000;
            4'h8: pat = 8'b1111_1110;
            4'h9: pat = 8'b1111_0110;
            4'hA: pat = 8'b1110_1110;
            4'hB: pat = 8'b0011_1110;  // Lower case b
            4'hC: pat = 8'b1001_1100;
            4'hD: pat = 8'b0111_1010;  // Lower case d
            4'hE: pat = 8'b1001_1110;
            default: pat = 8'b1000_1110;  // F
        endcase
        if (idx == board_pkg::w_digit_idx'(board_pkg::dot_digit))
            pat[0] = 1'b1;  // Separator dot
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan <= '0;  // No digit selected
        else
        begin
            scan.abcdefgh <= pat;
            scan.digit    <= board_pkg::digit_sel_t'(1) << idx;
        end
    end

endmodule

/* hdl/seg_digit_cell.sv */
`timescale 1ns/1ps

module seg_digit_cell
(
    input  logic            clk,
    input  logic            rst,
    input  logic            sel,       // This digit is on the bus
    input  board_pkg::seg_t abcdefgh,  // Scanned pattern
    output board_pkg::seg_t hgfedcba   // Held pattern, reversed
);

    board_pkg::seg_t hold;  // Last pattern seen for this digit

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            hold <= '0;  // Blank
        else if (sel)
            hold <= abcdefgh;
    end

    // --------------------
    // Bit reversal, a moves to bit 0

    always_comb
    begin
        for (int i = 0; i < $bits(board_pkg::seg_t); i++)
        begin
            hgfedcba[i] = hold[$bits(board_pkg::seg_t) - 1 - i];
        end
    end

endmodule

/* hdl/tm1638_tx.sv */
`timescale 1ns/1ps

module tm1638_tx
(
    input  logic                          clk,
    input  logic                          rst,
    input  board_pkg::seg_t               digits [board_pkg::n_digit],  // hgfedcba
    input  logic [board_pkg::n_digit - 1:0] leds,
    output logic                          sio_stb,
    output logic                          sio_clk,
    output logic                          sio_data
);

    localparam int w_div = board_pkg::tm_bit_div > 1 ? $clog2(board_pkg::tm_bit_div) : 1;
    localparam int w_gap = $clog2(board_pkg::tm_gap + 1);

    board_pkg::scan_state_t state;     // Current transfer
    board_pkg::scan_state_t nxt;       // Transfer after the strobe pause
    logic [w_div - 1:0]     div_cnt;   // Half period divider
    logic                   half;      // Half period boundary
    logic [3:0]             half_cnt;  // Bit counter, two halves per bit
    logic [3:0]             byte_cnt;  // Data byte 0..15
    logic [3:0]             nxt_idx;   // Following data byte
    logic [w_gap - 1:0]     gap_cnt;   // Frame gap clocks
    board_pkg::seg_t        shift;     // Outgoing byte, LSB first
    board_pkg::seg_t        nxt_byte;  // Byte after the current data byte
    board_pkg::seg_t        cmd_byte;  // Byte opening the next transfer

    assign half = (div_cnt == w_div'(board_pkg::tm_bit_div - 1));

    // Digit and LED bytes alternate
    assign nxt_idx  = byte_cnt + 4'd1;
    assign nxt_byte = nxt_idx[0] ? {7'b0, leds[nxt_idx[3:1]]} : digits[nxt_idx[3:1]];

    always_comb
    begin
        case (nxt)
            board_pkg::CMD:  cmd_byte = board_pkg::tm_cmd_write;
            board_pkg::ADDR: cmd_byte = board_pkg::tm_cmd_addr;
            default:         cmd_byte = board_pkg::tm_cmd_ctrl;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == board_pkg::IDLE && half && half_cnt[0])
            shift <= cmd_byte;                         // Transfer opens
        else if (state inside {board_pkg::CMD, board_pkg::ADDR, board_pkg::DATA,
                               board_pkg::CTRL} && half && half_cnt[0])
        begin
            if (half_cnt == 4'd15 && state == board_pkg::ADDR)
                shift <= digits[0];                    // First data byte
            else if (half_cnt == 4'd15 && state == board_pkg::DATA)
                shift <= nxt_byte;
            else
                shift <= shift >> 1;
        end
    end

    // --------------------
    // Control FSM

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= board_pkg::IDLE;
            nxt      <= board_pkg::CMD;
            div_cnt  <= '0;
            half_cnt <= '0;
            byte_cnt <= '0;
            gap_cnt  <= '0;
            sio_stb  <= 1'b1;
            sio_clk  <= 1'b1;
            sio_data <= 1'b1;
        end
        else
        begin
            div_cnt <= half ? '0 : div_cnt + w_div'(1);
            case (state)
                board_pkg::IDLE:
                    if (half)
                    begin
                        if (!half_cnt[0])
                        begin
                            sio_stb  <= 1'b1;  // Close previous transfer
                            half_cnt <= 4'd1;
                        end
                        else if (nxt == board_pkg::GAP)
                        begin
                            state   <= board_pkg::GAP;
                            gap_cnt <= '0;
                        end
                        else
                        begin
                            sio_stb  <= 1'b0;  // Open next transfer
                            state    <= nxt;
                            half_cnt <= '0;
                        end
                    end
                board_pkg::GAP:
                    if (gap_cnt == w_gap'(board_pkg::tm_gap - 1))
                    begin
                        state    <= board_pkg::IDLE;
                        nxt      <= board_pkg::CMD;
                        half_cnt <= 4'd1;  // Strobe already high
                    end
                    else
                        gap_cnt <= gap_cnt + w_gap'(1);
                default:
                    if (half)
                    begin
                        half_cnt <= half_cnt + 4'd1;
                        if (!half_cnt[0])
                        begin
                            sio_clk  <= 1'b0;
                            sio_data <= shift[0];  // Set up while clock is low
                        end
                        else
                        begin
                            sio_clk <= 1'b1;       // Receiver samples here
                            if (half_cnt == 4'd15)
                            begin
                                case (state)
                                    board_pkg::CMD:
                                    begin
                                        state <= board_pkg::IDLE;
                                        nxt   <= board_pkg::ADDR;
                                    end
                                    board_pkg::ADDR:
                                    begin
                                        state    <= board_pkg::DATA;
                                        byte_cnt <= '0;
                                    end
                                    board_pkg::DATA:
                                        if (byte_cnt == 4'd15)
                                        begin
                                            state <= board_pkg::IDLE;
                                            nxt   <= board_pkg::CTRL;
                                        end
                                        else
                                            byte_cnt <= nxt_idx;
                                    default:
                                    begin
                                        state <= board_pkg::IDLE;  // After CTRL
                                        nxt   <= board_pkg::GAP;
                                    end
                                endcase
                            end
                        end
                    end
            endcase
        end
    end

endmodule

/* hdl/board_top.sv */
`timescale 1ns/1ps

`include "board_config.svh"

module board_top
(
    input  logic                 clk,
    input  logic [`w_key - 1:0]  key,   // Active low
    input  logic [`w_sw - 1:0]   sw,    // Top switch is reset
    output logic [`w_led - 1:0]  led,
    output logic [7:0]           hex0,  // Active low, hgfedcba
    output logic [7:0]           hex1,
    output logic [7:0]           hex2,
    output logic [7:0]           hex3,
    output logic [7:0]           hex4,
    output logic [7:0]           hex5,
    output logic                 sio_stb,
    output logic                 sio_clk,
    output logic                 sio_data
);

    // --------------------
    // Board inputs

    logic                        rst;
    logic [`w_key - 1:0]         key_on;     // Pressed is one
    logic                        scan_tick;
    logic                        step_tick;
    board_pkg::count_t           count;
    board_pkg::scan_bus_t        scan;
    board_pkg::seg_t             held [board_pkg::n_digit];  // Per-digit hold, hgfedcba
    logic [7:0]                  hex_n [`w_hex];

    assign rst    = sw[`w_sw - 1];
    assign key_on = ~key;

    rate_strobe #(.div(board_pkg::scan_div)) i_scan_strobe
    (
        .clk  (clk),
        .rst  (rst),
        .tick (scan_tick)
    );

    rate_strobe #(.div(board_pkg::step_div)) i_step_strobe
    (
        .clk  (clk),
        .rst  (rst),
        .tick (step_tick)
    );

    hex_counter_lab i_hex_counter_lab
    (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick),
        .key       (key_on),
        .sw        (sw[`w_sw - 2:0]),
        .count     (count)
    );

    digit_scanner i_digit_scanner
    (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .count     (count),
        .scan      (scan)
    );

    // --------------------
    // Static digit cells

    for (genvar i = 0; i < board_pkg::n_digit; i++)
    begin : g_cell
        seg_digit_cell i_cell
        (
            .clk      (clk),
            .rst      (rst),
            .sel      (scan.digit[i]),
            .abcdefgh (scan.abcdefgh),
            .hgfedcba (held[i])
        );
    end

    for (genvar i = 0; i < `w_hex; i++)
    begin : g_hex
        assign hex_n[i] = ~held[i];  // Segments light on zero
    end

    assign hex0 = hex_n[0];
    assign hex1 = hex_n[1];
    assign hex2 = hex_n[2];
    assign hex3 = hex_n[3];
    assign hex4 = hex_n[4];
    assign hex5 = hex_n[5];

    assign led = count[`w_led - 1:0];

    tm1638_tx i_tm1638_tx
    (
        .clk      (clk),
        .rst      (rst),
        .digits   (held),
        .leds     (count[board_pkg::n_digit - 1:0]),  // Same low bits as the board LEDs
        .sio_stb  (sio_stb),
        .sio_clk  (sio_clk),
        .sio_data (sio_data)
    );

endmodule

/* test/tb_board_top.sv */
`timescale 1ns/1ps

`include "board_config.svh"

module tb_board_top;

    localparam int clk_period = 4;
    localparam int n_reset    = 4;                                // Cycles in reset
    localparam int n_periods  = 40;                               // Step periods to run
    localparam int run_cycles = n_periods * board_pkg::step_div;
    localparam int settle     = 70;                               // Display refresh bound
    localparam int min_frames = 8;                                // About 16 fit in the run
    localparam int timeout_ns = (n_reset + run_cycles + 2000) * clk_period;

    logic                clk;
    logic [`w_key - 1:0] key;        // Active low
    logic [`w_sw - 1:0]  sw;         // Top bit is reset
    logic [`w_led - 1:0] led;
    logic [7:0]          hex [`w_hex];
    logic                sio_stb;
    logic                sio_clk;
    logic                sio_data;

    // --------------------
    // Stimulus and model

    logic [31:0]         rnd;        // LCG state
    logic [`w_sw - 2:0]  sw_low;     // Step increment minus one
    logic                clear_on;   // Key 0 pressed
    logic                hold_on;    // Key 1 pressed
    board_pkg::count_t   m_count;    // Expected counter
    int                  change_cycle [board_pkg::n_digit];  // Last nibble change
    int                  cyc;        // Clocks since reset release
    int                  err_led;
    int                  err_hex;
    int                  err_other;

    // TM1638 decoder state
    logic [7:0]          rx_shift;
    logic [7:0]          rx_bytes [$];
    board_pkg::count_t   load_count [$];                      // Model count as each byte loads
    logic [board_pkg::n_digit - 1:0] load_settled [$];        // Settled cells as each byte loads
    int                  rx_bits;
    int                  xfer_idx;   // Which of the three transfers
    int                  frames;
    int                  err_tm;

    board_top i_board_top
    (
        .clk      (clk),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .hex0     (hex[0]),
        .hex1     (hex[1]),
        .hex2     (hex[2]),
        .hex3     (hex[3]),
        .hex4     (hex[4]),
        .hex5     (hex[5]),
        .sio_stb  (sio_stb),
        .sio_clk  (sio_clk),
        .sio_data (sio_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Seven-segment glyphs in hgfedcba order with lit segments as ones
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;  // b c
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;  // a b c
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;  // Lower case b
            4'hC: return 8'h39;
            4'hD: return 8'h5E;  // Lower case d
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    function automatic logic [7:0] digit_byte(input board_pkg::count_t c, input int i);
        logic [7:0] pat;
        pat = seg_pattern(c[i * 4 +: 4]);
        if (i == 4)
            pat[7] = 1'b1;  // Separator dot
        return pat;
    endfunction

    // Digits whose cells have had time to pick up the current nibble
    function automatic logic [board_pkg::n_digit - 1:0] settled_digits();
        logic [board_pkg::n_digit - 1:0] s;
        for (int i = 0; i < board_pkg::n_digit; i++)
            s[i] = (change_cycle[i] + settle < cyc);
        return s;
    endfunction

    // --------------------
    // Clock and watchdog

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(timeout_ns);
        $display("Timeout: run did not complete within %0d ns", timeout_ns);
        $display("Verification failed");
        $finish;
    end

    task automatic step_model();
        board_pkg::count_t prev;
        prev = m_count;
        if (clear_on)
            m_count = '0;                    // Clear on any edge
        else if (cyc % board_pkg::step_div == 0 && !hold_on)
            m_count = m_count + board_pkg::count_t'(sw_low) + 32'd1;
        for (int i = 0; i < board_pkg::n_digit; i++)
        begin
            if (prev[i * 4 +: 4] != m_count[i * 4 +: 4])
                change_cycle[i] = cyc;
        end
    endtask

    task automatic draw_inputs();
        rnd      = lcg_next(rnd);
        sw_low   = rnd[24:16];
        rnd      = lcg_next(rnd);
        clear_on = (rnd[31:29] == 3'd0);    // About one in eight
        rnd      = lcg_next(rnd);
        hold_on  = (rnd[31:29] == 3'd0);
        key      = ~{hold_on, clear_on};
        sw       = {1'b0, sw_low};
    endtask

    task automatic expect_blank_outputs();
        for (int i = 0; i < `w_hex; i++)
        begin
            assert (hex[i] == 8'hFF) else
            begin
                err_other++;
                $display("FAIL %0t: hex%0d is %h after reset, expected ff",
                         $time, i, hex[i]);
            end
        end
        assert (led == '0 && sio_stb == 1'b1) else
        begin
            err_other++;
            $display("FAIL %0t: led %h stb %b after reset, expected 0 and 1",
                     $time, led, sio_stb);
        end
    endtask

    task automatic compare_hex_digits();
        logic [7:0] exp;
        for (int i = 0; i < `w_hex; i++)
        begin
            exp = ~digit_byte(m_count, i);   // Active low
            assert (hex[i] == exp) else
            begin
                err_hex++;
                $display("FAIL %0t: hex%0d is %h, expected %h for count %h",
                         $time, i, hex[i], exp, m_count);
            end
        end
    endtask

    // --------------------
    // TM1638 frame checks

    task automatic verify_transfer();
        logic [7:0]                      first_exp;
        logic [7:0]                      exp;
        int                              exp_len;
        board_pkg::count_t               snap;
        logic [board_pkg::n_digit - 1:0] settled;
        case (xfer_idx)
            0:
            begin
                first_exp = 8'h40;
                exp_len   = 1;
            end
            1:
            begin
                first_exp = 8'hC0;
                exp_len   = 17;
            end
            default:
            begin
                first_exp = 8'h8F;
                exp_len   = 1;
            end
        endcase
        assert (rx_bits == exp_len * 8) else
        begin
            err_tm++;
            $display("FAIL %0t: TM1638 transfer %0d has %0d bits, expected %0d",
                     $time, xfer_idx, rx_bits, exp_len * 8);
        end
        if (rx_bytes.size() > 0)
        begin
            assert (rx_bytes[0] == first_exp) else
            begin
                err_tm++;
                $display("FAIL %0t: TM1638 command %h, expected %h",
                         $time, rx_bytes[0], first_exp);
            end
        end
        if (xfer_idx == 1 && rx_bytes.size() == 17)
        begin
            for (int i = 0; i < board_pkg::n_digit; i++)
            begin
                snap    = load_count[2 * i];     // Taken as the digit byte loaded
                settled = load_settled[2 * i];
                if (settled[i])
                begin
                    exp = digit_byte(snap, i);
                    assert (rx_bytes[1 + 2 * i] == exp) else
                    begin
                        err_tm++;
                        $display("FAIL %0t: TM1638 digit %0d is %h, expected %h",
                                 $time, i, rx_bytes[1 + 2 * i], exp);
                    end
                end
                snap = load_count[1 + 2 * i];    // Taken as the LED byte loaded
                exp  = {7'b0, snap[i]};
                assert (rx_bytes[2 + 2 * i] == exp) else
                begin
                    err_tm++;
                    $display("FAIL %0t: TM1638 led %0d is %h, expected %h",
                             $time, i, rx_bytes[2 + 2 * i], exp);
                end
            end
        end
    endtask

    initial
    begin
        xfer_idx = 0;
        frames   = 0;
        err_tm   = 0;
        forever
        begin
            @(negedge sio_stb);                // Transfer opens
            rx_bits = 0;
            rx_bytes.delete();
            load_count.delete();
            load_settled.delete();
            @(posedge sio_clk or posedge sio_stb);
            while (sio_stb !== 1'b1)
            begin
                rx_shift = {sio_data, rx_shift[7:1]};  // LSB first
                rx_bits++;
                if (rx_bits % 8 == 0)
                begin
                    rx_bytes.push_back(rx_shift);
                    load_count.push_back(m_count);     // Next byte is sampled on this edge
                    load_settled.push_back(settled_digits());
                end
                @(posedge sio_clk or posedge sio_stb);
            end
            verify_transfer();
            xfer_idx = (xfer_idx + 1) % 3;
            if (xfer_idx == 0)
                frames++;
        end
    end

    // --------------------
    // Main sequence

    initial
    begin
        rnd       = 32'h63b2;
        sw_low    = '0;
        clear_on  = 1'b0;
        hold_on   = 1'b0;
        key       = '1;                        // Released
        sw        = {1'b1, sw_low};            // Reset on
        m_count   = '0;
        cyc       = 0;
        err_led   = 0;
        err_hex   = 0;
        err_other = 0;
        for (int i = 0; i < board_pkg::n_digit; i++)
            change_cycle[i] = 0;

        repeat (n_reset) @(negedge clk);
        expect_blank_outputs();
        sw[`w_sw - 1] = 1'b0;                  // Release reset

        while (cyc < run_cycles)
        begin
            @(negedge clk);
            cyc++;
            step_model();                      // Edge that just passed
            assert (led == m_count[`w_led - 1:0]) else
            begin
                err_led++;
                $display("FAIL %0t: led %h, expected %h", $time, led, m_count[`w_led - 1:0]);
            end
            if (cyc == 1)
                expect_blank_outputs();
            if (cyc % board_pkg::step_div == settle)
                compare_hex_digits();
            if (cyc % board_pkg::step_div == board_pkg::step_div / 2)
                draw_inputs();                 // Mid period away from the step edge
        end

        assert (frames >= min_frames) else
        begin
            err_other++;
            $display("Only %0d TM1638 frames were decoded, at least %0d expected",
                     frames, min_frames);
        end

        $display("Errors: led %0d, hex %0d, tm1638 %0d, other %0d",
                 err_led, err_hex, err_tm, err_other);
        if (err_led + err_hex + err_tm + err_other == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hdl/board_pkg.sv
hdl/rate_strobe.sv
hdl/hex_counter_lab.sv
hdl/digit_scanner.sv
hdl/seg_digit_cell.sv
hdl/tm1638_tx.sv
hdl/board_top.sv
test/tb_board_top.sv

/* run.sh */
#!/bin/sh
# Build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_board_top -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_board_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
